/* Makefile */
VERILATOR ?= verilator
TOP       ?= controlUnitTb
RTL_TOP   ?= controlUnit
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --assert --timing --timescale 1ns/1ps
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
rtl/cpuCtrlPkg.sv
rtl/ctrlIf.sv
rtl/aluGroupDecoder.sv
rtl/ldsGroupDecoder.sv
rtl/jmpGroupDecoder.sv
rtl/intSequencer.sv
rtl/opxMultiplexer.sv
rtl/controlUnit.sv
verif/controlUnitTb.sv

/* rtl/aluGroupDecoder.sv */
`timescale 1ns/1ps

module aluGroupDecoder (
	input cpuCtrlPkg::instrFields fields,
	ctrlIf.src out
);
	import cpuCtrlPkg::*;

	always_comb begin
		out.word = CTRL_DEFAULT;
		out.word.aluOp = fields.subOp; // sub-op is the ALU op code
		out.word.aluaSrc = ALUA_SRC_REG_A;
		out.word.alubSrc = ALUB_SRC_REG_B;
		out.word.regSeq = REG_SEQ_WRITE_A; // result back into reg A
		out.word.regaAddr = REGA_ADDR_ARGA;
		out.word.regbAddr = REGB_ADDR_ARGB;

		// a plain move leaves the flags alone
		out.ccLoad = (fields.subOp != ALU_OP_MOV);
	end

endmodule

/* rtl/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
	input  logic clk,
	input  logic rstN,
	input  logic instrValid,
	input  logic [15:0] instr,
	input  logic debugMode,
	input  logic [3:0] debugArgB,
	input  cpuCtrlPkg::addrBusT debugAddrBus,
	input  cpuCtrlPkg::busSeqT debugBusSeq,
	input  cpuCtrlPkg::ccRegT debugCcReg,
	input  cpuCtrlPkg::pcNextT debugPcNext,
	input  cpuCtrlPkg::regSeqT debugRegSeq,
	input  logic intReq,
	output logic ctrlValid,
	output cpuCtrlPkg::ctrlWord ctrl,
	output logic intAck
);
	import cpuCtrlPkg::*;

	instrFields instrQ; // stage-1 instruction
	logic       validQ;
	ccRegT      intCcReg;
	pcNextT     intPcNext;

	always_ff @(posedge clk) begin
		if (!rstN)
			validQ <= 1'b0;
		else
			validQ <= instrValid;
	end

	always_ff @(posedge clk) begin
		if (instrValid)
			instrQ <= instrFields'(instr);
	end

	ctrlIf aluIf ();
	ctrlIf ldsIf ();
	ctrlIf jmpIf ();

	aluGroupDecoder aluDec (.fields(instrQ), .out(aluIf.src));
	ldsGroupDecoder ldsDec (.fields(instrQ), .out(ldsIf.src));
	jmpGroupDecoder jmpDec (.fields(instrQ), .out(jmpIf.src));

	intSequencer intSeq (
		.clk(clk), .rstN(rstN), .valid(validQ), .debugMode(debugMode),
		.intReq(intReq), .ccReg(intCcReg), .pcNext(intPcNext), .intAck(intAck)
	);

	opxMultiplexer opxMux (
		.clk(clk), .rstN(rstN), .valid(validQ), .group(instrQ.group),
		.argB(instrQ.argB), .debugMode(debugMode), .debugAddrBus(debugAddrBus),
		.debugArgB(debugArgB), .debugBusSeq(debugBusSeq), .debugCcReg(debugCcReg),
		.debugPcNext(debugPcNext), .debugRegSeq(debugRegSeq),
		.alu(aluIf.dst), .lds(ldsIf.dst), .jmp(jmpIf.dst),
		.intCcReg(intCcReg), .intPcNext(intPcNext),
		.ctrlValid(ctrlValid), .ctrl(ctrl)
	);

endmodule

/* rtl/cpuCtrlPkg.sv */
package cpuCtrlPkg;

	// instruction groups, top two bits of the word
	typedef logic [1:0] groupT;
	localparam groupT GROUP_SYSTEM      = 2'd0;
	localparam groupT GROUP_LOAD_STORE  = 2'd1;
	localparam groupT GROUP_JUMP        = 2'd2;
	localparam groupT GROUP_ARITH_LOGIC = 2'd3;

	typedef logic [3:0] aluOpT;
	localparam aluOpT ALU_OP_MOV = 4'd0;
	localparam aluOpT ALU_OP_ADD = 4'd1;

	typedef logic [2:0] aluaSrcT;
	localparam aluaSrcT ALUA_SRC_REG_A = 3'd0;

	typedef logic [2:0] alubSrcT;
	localparam alubSrcT ALUB_SRC_REG_B = 3'd0;
	localparam alubSrcT ALUB_SRC_IMM   = 3'd1; // imm field of the instruction

	typedef logic [2:0] addrBusT;
	localparam addrBusT ADDR_BUS_PC_A = 3'd0;
	localparam addrBusT ADDR_BUS_REGB = 3'd1;
	localparam addrBusT ADDR_BUS_SP   = 3'd2; // stack pointer, used by call

	typedef logic [1:0] busSeqT;
	localparam busSeqT BUS_SEQ_NONE  = 2'd0;
	localparam busSeqT BUS_SEQ_READ  = 2'd1;
	localparam busSeqT BUS_SEQ_WRITE = 2'd2;

	typedef logic [1:0] dataBusT;
	localparam dataBusT DATA_BUS_REGA_DOUT = 2'd0;
	localparam dataBusT DATA_BUS_ALU_R     = 2'd1;

	typedef logic [1:0] pcBaseT;
	localparam pcBaseT PC_BASE_PC_A = 2'd0;

	typedef logic [1:0] pcOffsetT;
	localparam pcOffsetT PC_OFFSET_2 = 2'd1;

	typedef logic [3:0] regSeqT;
	localparam regSeqT REG_SEQ_NONE    = 4'd0;
	localparam regSeqT REG_SEQ_WRITE_A = 4'd1;
	localparam regSeqT REG_SEQ_LOAD    = 4'd2;
	localparam regSeqT REG_SEQ_PUSH_PC = 4'd3; // return address onto the stack

	typedef logic [1:0] regaAddrT;
	localparam regaAddrT REGA_ADDR_ARGA = 2'd0;

	typedef logic [1:0] regaDinT;
	localparam regaDinT REGA_DIN_DIN   = 2'd0;
	localparam regaDinT REGA_DIN_ALU_R = 2'd1;

	typedef logic [2:0] regbAddrT;
	localparam regbAddrT REGB_ADDR_ARGB = 3'd0;

	typedef logic [1:0] ccRegT;
	localparam ccRegT CC_REG_HOLD = 2'd0;
	localparam ccRegT CC_REG_SAVE = 2'd2;

	typedef logic [2:0] pcNextT;
	localparam pcNextT PC_NEXT_SEQ    = 3'd0;
	localparam pcNextT PC_NEXT_VECTOR = 3'd4;

	localparam logic BYTE_WORD = 1'b0;
	localparam logic BYTE_BYTE = 1'b1;

	typedef struct packed {
		addrBusT  addrBus;
		aluOpT    aluOp;
		aluaSrcT  aluaSrc;
		alubSrcT  alubSrc;
		logic [3:0] argB;
		busSeqT   busSeq;
		logic     byteSel;
		logic     ccLoad;
		ccRegT    ccReg;
		dataBusT  dataBus;
		pcBaseT   pcBase;
		pcNextT   pcNext;
		pcOffsetT pcOffset;
		regSeqT   regSeq;
		regaAddrT regaAddr;
		regaDinT  regaDin;
		regbAddrT regbAddr;
	} ctrlWord;

	typedef struct packed {
		groupT      group;
		logic [3:0] subOp;
		logic [1:0] argA;
		logic [3:0] argB;
		logic [3:0] imm;
	} instrFields;

	// idle word, also the base for debug mode and the system group
	localparam ctrlWord CTRL_DEFAULT = '{
		addrBus: ADDR_BUS_PC_A, aluOp: ALU_OP_MOV, aluaSrc: ALUA_SRC_REG_A,
		alubSrc: ALUB_SRC_REG_B, argB: 4'd0, busSeq: BUS_SEQ_NONE,
		byteSel: BYTE_WORD, ccLoad: 1'b0, ccReg: CC_REG_HOLD,
		dataBus: DATA_BUS_REGA_DOUT, pcBase: PC_BASE_PC_A, pcNext: PC_NEXT_SEQ,
		pcOffset: PC_OFFSET_2, regSeq: REG_SEQ_NONE, regaAddr: REGA_ADDR_ARGA,
		regaDin: REGA_DIN_DIN, regbAddr: REGB_ADDR_ARGB
	};

endpackage

/* rtl/ctrlIf.sv */
`timescale 1ns/1ps

// partial control word from one group decoder
interface ctrlIf;
	import cpuCtrlPkg::*;

	ctrlWord word;  // fields the group does not own stay at CTRL_DEFAULT
	logic    ccLoad;

	modport src (
		output word,
		output ccLoad
	);

	modport dst (
		input word,
		input ccLoad
	);

endinterface

/* rtl/intSequencer.sv */
`timescale 1ns/1ps

module intSequencer (
	input  logic clk,
	input  logic rstN,
	input  logic valid,     // stage-1 instruction present
	input  logic debugMode,
	input  logic intReq,    // level
	output cpuCtrlPkg::ccRegT  ccReg,
	output cpuCtrlPkg::pcNextT pcNext,
	output logic intAck
);
	import cpuCtrlPkg::*;

	logic pending;
	logic take;

	// interrupts wait while debug mode is on
	assign take = valid && !debugMode && pending;

	assign ccReg = take ? CC_REG_SAVE : CC_REG_HOLD;
	assign pcNext = take ? PC_NEXT_VECTOR : PC_NEXT_SEQ;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pending <= 1'b0;
			intAck <= 1'b0;
		end else begin
			intAck <= take; // lines up with ctrlValid of the taking instruction
			if (take)
				pending <= 1'b0;
			else if (intReq)
				pending <= 1'b1;
		end
	end

endmodule

/* rtl/jmpGroupDecoder.sv */
`timescale 1ns/1ps

module jmpGroupDecoder (
	input cpuCtrlPkg::instrFields fields,
	ctrlIf.src out
);
	import cpuCtrlPkg::*;

	logic isCall;

	assign isCall = (fields.subOp == 4'hf);

	always_comb begin
		out.word = CTRL_DEFAULT;
		out.word.pcBase = pcBaseT'(fields.subOp[1:0]);
		out.word.pcOffset = pcOffsetT'(fields.subOp[3:2]);
		out.word.alubSrc = ALUB_SRC_REG_B;

		if (isCall) begin
			// push the return address before the jump
			out.word.addrBus = ADDR_BUS_SP;
			out.word.busSeq = BUS_SEQ_WRITE;
			out.word.regSeq = REG_SEQ_PUSH_PC;
		end else begin
			out.word.addrBus = ADDR_BUS_PC_A;
			out.word.busSeq = BUS_SEQ_NONE;
			out.word.regSeq = REG_SEQ_NONE;
		end

		out.word.regaDin = REGA_DIN_DIN;
		out.word.regaAddr = REGA_ADDR_ARGA;
		out.word.regbAddr = REGB_ADDR_ARGB;
		out.ccLoad = 1'b0;
	end

endmodule

/* rtl/ldsGroupDecoder.sv */
`timescale 1ns/1ps

module ldsGroupDecoder (
	input cpuCtrlPkg::instrFields fields,
	ctrlIf.src out
);
	import cpuCtrlPkg::*;

	logic isStore;
	logic isByte;

	assign isStore = fields.subOp[3];
	assign isByte = fields.subOp[2];

	always_comb begin
		out.word = CTRL_DEFAULT;

		// effective address is reg B plus the immediate
		out.word.addrBus = ADDR_BUS_REGB;
		out.word.aluOp = ALU_OP_ADD;
		out.word.aluaSrc = ALUA_SRC_REG_A;
		out.word.alubSrc = ALUB_SRC_IMM;

		out.word.busSeq = isStore ? BUS_SEQ_WRITE : BUS_SEQ_READ;
		out.word.byteSel = isByte ? BYTE_BYTE : BYTE_WORD;
		out.word.dataBus = DATA_BUS_REGA_DOUT; // store data from reg A
		out.word.regaDin = REGA_DIN_DIN;       // load data from the bus
		out.word.regSeq = isStore ? REG_SEQ_NONE : REG_SEQ_LOAD;

		out.word.pcOffset = PC_OFFSET_2;
		out.word.regaAddr = REGA_ADDR_ARGA;
		out.word.regbAddr = REGB_ADDR_ARGB;

		out.ccLoad = 1'b0;
	end

endmodule

/* rtl/opxMultiplexer.sv */
`timescale 1ns/1ps

module opxMultiplexer (
	input  logic clk,
	input  logic rstN,
	input  logic valid,
	input  cpuCtrlPkg::groupT group,
	input  logic [3:0] argB,
	input  logic debugMode,
	input  cpuCtrlPkg::addrBusT debugAddrBus,
	input  logic [3:0] debugArgB,
	input  cpuCtrlPkg::busSeqT debugBusSeq,
	input  cpuCtrlPkg::ccRegT debugCcReg,
	input  cpuCtrlPkg::pcNextT debugPcNext,
	input  cpuCtrlPkg::regSeqT debugRegSeq,
	ctrlIf.dst alu,
	ctrlIf.dst lds,
	ctrlIf.dst jmp,
	input  cpuCtrlPkg::ccRegT intCcReg,
	input  cpuCtrlPkg::pcNextT intPcNext,
	output logic ctrlValid,
	output cpuCtrlPkg::ctrlWord ctrl
);
	import cpuCtrlPkg::*;

	ctrlWord nextCtrl;

	always_comb begin
		nextCtrl = CTRL_DEFAULT;
		if (debugMode) begin
			// only the debug port's fields, everything else idle
			nextCtrl.addrBus = debugAddrBus;
			nextCtrl.argB = debugArgB;
			nextCtrl.busSeq = debugBusSeq;
			nextCtrl.ccReg = debugCcReg;
			nextCtrl.pcNext = debugPcNext;
			nextCtrl.regSeq = debugRegSeq;
		end else begin
			nextCtrl.ccReg = intCcReg;
			nextCtrl.pcNext = intPcNext;
			nextCtrl.argB = argB;
			case (group)
				GROUP_LOAD_STORE: begin
					nextCtrl.addrBus = lds.word.addrBus;
					nextCtrl.aluOp = lds.word.aluOp;
					nextCtrl.aluaSrc = lds.word.aluaSrc;
					nextCtrl.alubSrc = lds.word.alubSrc;
					nextCtrl.busSeq = lds.word.busSeq;
					nextCtrl.byteSel = lds.word.byteSel;
					nextCtrl.ccLoad = lds.ccLoad;
					nextCtrl.dataBus = lds.word.dataBus;
					nextCtrl.pcOffset = lds.word.pcOffset;
					nextCtrl.regSeq = lds.word.regSeq;
					nextCtrl.regaAddr = lds.word.regaAddr;
					nextCtrl.regaDin = lds.word.regaDin;
					nextCtrl.regbAddr = lds.word.regbAddr;
				end
				GROUP_JUMP: begin
					nextCtrl.addrBus = jmp.word.addrBus;
					nextCtrl.alubSrc = jmp.word.alubSrc;
					nextCtrl.busSeq = jmp.word.busSeq;
					nextCtrl.ccLoad = jmp.ccLoad;
					nextCtrl.pcBase = jmp.word.pcBase;
					nextCtrl.pcOffset = jmp.word.pcOffset;
					nextCtrl.regSeq = jmp.word.regSeq;
					nextCtrl.regaDin = jmp.word.regaDin;
					nextCtrl.regaAddr = jmp.word.regaAddr;
					nextCtrl.regbAddr = jmp.word.regbAddr;
				end
				GROUP_ARITH_LOGIC: begin
					nextCtrl.aluOp = alu.word.aluOp;
					nextCtrl.aluaSrc = alu.word.aluaSrc;
					nextCtrl.alubSrc = alu.word.alubSrc;
					nextCtrl.ccLoad = alu.ccLoad; // only group that touches the flags
					nextCtrl.dataBus = DATA_BUS_ALU_R;
					nextCtrl.regSeq = alu.word.regSeq;
					nextCtrl.regaAddr = alu.word.regaAddr;
					nextCtrl.regaDin = REGA_DIN_ALU_R;
					nextCtrl.regbAddr = alu.word.regbAddr;
				end
				default: begin
					// system group keeps the idle word
					nextCtrl.busSeq = BUS_SEQ_NONE;
					nextCtrl.regSeq = REG_SEQ_NONE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			ctrlValid <= 1'b0;
		else
			ctrlValid <= valid;
	end

	always_ff @(posedge clk) begin
		if (valid)
			ctrl <= nextCtrl;
	end

	ccLoadOnlyArith: assert property (@(posedge clk) disable iff (!rstN)
		valid && (debugMode || group != GROUP_ARITH_LOGIC) |=> !ctrl.ccLoad);

	// a move never loads the flags
	noCcLoadOnMov: assert property (@(posedge clk) disable iff (!rstN)
		ctrlValid && ctrl.ccLoad |-> ctrl.aluOp != ALU_OP_MOV);

endmodule

/* verif/controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb;
	import cpuCtrlPkg::*;

	localparam int NUM_VEC = 20;
	localparam int COLS = 12;    // values per line of the stimulus file
	localparam int LATENCY = 2;  // strobe to ctrlValid, both seen at the falling edge
	localparam int TIMEOUT_CYCLES = (NUM_VEC + 10) * 4;

	logic        clk;
	logic        rstN;
	logic        instrValid;
	logic [15:0] instr;
	logic        debugMode;
	logic [3:0]  debugArgB;
	addrBusT     debugAddrBus;
	busSeqT      debugBusSeq;
	ccRegT       debugCcReg;
	pcNextT      debugPcNext;
	regSeqT      debugRegSeq;
	logic        intReq;
	logic        ctrlValid;
	ctrlWord     ctrl;
	logic        intAck;

	logic [63:0] stim [NUM_VEC*COLS];
	int          cycleCount = 0;
	int          checkedCount = 0;
	int          errorCount = 0;
	int          testsPassed = 0;
	int          testsFailed = 0;
	bit          resetChecked = 1'b0;
	int          issueQ [$]; // cycle of each strobe still in flight

	controlUnit dut (
		.clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
		.debugMode(debugMode), .debugArgB(debugArgB), .debugAddrBus(debugAddrBus),
		.debugBusSeq(debugBusSeq), .debugCcReg(debugCcReg), .debugPcNext(debugPcNext),
		.debugRegSeq(debugRegSeq), .intReq(intReq),
		.ctrlValid(ctrlValid), .ctrl(ctrl), .intAck(intAck)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, only %0d of %0d instructions came back",
				cycleCount, checkedCount, NUM_VEC);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic checkValue(input string testName, input string what,
			input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s %s: expected %h, actual %h", testName, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string testName, input bit ok);
		if (ok) begin
			testsPassed++;
			$display("test %s: pass", testName);
		end else begin
			testsFailed++;
			$display("test %s: failed", testName);
		end
	endtask

	task automatic checkVector(input int idx);
		int    b;
		int    errorsBefore;
		string testName;
		b = idx * COLS;
		errorsBefore = errorCount;
		testName = $sformatf("vec%02h", stim[b][7:0]);
		checkValue(testName, "ctrl", stim[b+10], 64'(ctrl));
		checkValue(testName, "intAck", stim[b+11], 64'(intAck));
		checkValue(testName, "latency", 64'(LATENCY), 64'(cycleCount - issueQ.pop_front()));
		reportTest(testName, errorCount == errorsBefore);
	endtask

	// one clock slot: a new instruction plus the debug side of the one in stage 1
	task automatic driveSlot(input int instrIdx, input int dbgIdx);
		int bi;
		int bd;
		bi = instrIdx * COLS;
		bd = dbgIdx * COLS;
		if (instrIdx >= 0 && instrIdx < NUM_VEC) begin
			instrValid <= 1'b1;
			instr <= stim[bi+1][15:0];
		end else begin
			instrValid <= 1'b0;
			instr <= 16'h0;
		end
		if (dbgIdx >= 0 && dbgIdx < NUM_VEC) begin
			debugMode <= stim[bd+2][0];
			debugArgB <= stim[bd+3][3:0];
			debugAddrBus <= stim[bd+4][2:0];
			debugBusSeq <= stim[bd+5][1:0];
			debugCcReg <= stim[bd+6][1:0];
			debugPcNext <= stim[bd+7][2:0];
			debugRegSeq <= stim[bd+8][3:0];
			intReq <= stim[bd+9][0]; // one-cycle level, the next instruction takes it
		end else begin
			debugMode <= 1'b0;
			debugArgB <= 4'h0;
			debugAddrBus <= ADDR_BUS_PC_A;
			debugBusSeq <= BUS_SEQ_NONE;
			debugCcReg <= CC_REG_HOLD;
			debugPcNext <= PC_NEXT_SEQ;
			debugRegSeq <= REG_SEQ_NONE;
			intReq <= 1'b0;
		end
	endtask

	// outputs are sampled half a cycle away from the driving edge
	always @(negedge clk) begin
		if (rstN && !resetChecked) begin
			checkValue("reset", "ctrlValid", 64'd0, 64'(ctrlValid));
			checkValue("reset", "intAck", 64'd0, 64'(intAck));
			reportTest("reset", errorCount == 0); // first test of the run
			resetChecked = 1'b1;
		end else if (rstN) begin
			if (intAck && !ctrlValid) begin
				$display("intAck pulsed while no control word was leaving the stage");
				errorCount++;
			end
			if (ctrlValid) begin
				if (checkedCount >= NUM_VEC || issueQ.size() == 0) begin
					$display("ctrlValid went high with no instruction in flight");
					errorCount++;
				end else begin
					checkVector(checkedCount);
					checkedCount++;
				end
			end
		end
		if (rstN && instrValid)
			issueQ.push_back(cycleCount);
	end

	initial begin
		int k;
		bit loadOk;
		rstN = 1'b0;
		instrValid = 1'b1; // strobe and request held through reset, both ignored
		instr = 16'h0;
		debugMode = 1'b0;
		debugArgB = 4'h0;
		debugAddrBus = ADDR_BUS_PC_A;
		debugBusSeq = BUS_SEQ_NONE;
		debugCcReg = CC_REG_HOLD;
		debugPcNext = PC_NEXT_SEQ;
		debugRegSeq = REG_SEQ_NONE;
		intReq = 1'b1;
		$readmemh("verif/ctrlStim.txt", stim);
		loadOk = 1'b1;
		for (k = 0; k < NUM_VEC; k++) begin
			if (stim[k*COLS] !== 64'(k))
				loadOk = 1'b0;
		end
		if (!loadOk) begin
			$display("stimulus file verif/ctrlStim.txt is missing or its test ids are out of order");
			$display("Simulation finished: FAIL");
			$finish;
		end else begin
			repeat (4) @(posedge clk);
			rstN <= 1'b1;
			instrValid <= 1'b0;
			intReq <= 1'b0;
			for (k = 0; k <= NUM_VEC; k++) begin
				@(posedge clk);
				driveSlot(k, k - 1);
			end
			@(posedge clk);
			driveSlot(-1, -1);
			wait (checkedCount == NUM_VEC);
			repeat (3) @(negedge clk); // room for a stray ctrlValid or intAck
			$display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
				testsPassed + testsFailed, testsPassed, testsFailed, errorCount);
			if (errorCount == 0 && testsFailed == 0)
				$display("Simulation finished: PASS");
			else
				$display("Simulation finished: FAIL");
			$finish;
		end
	end

endmodule

/* verif/ctrlStim.txt */
// id instr debugMode debugArgB debugAddrBus debugBusSeq debugCcReg debugPcNext debugRegSeq
//    intReq expectedCtrl expectedIntAck (all hex, one test per line)
00 c535 0 0 0 0 0 0 0 0 0100c440888 0 // alu add
01 c270 0 0 0 0 0 0 0 0 0001c040888 0 // alu mov, no cc load
02 d4a1 0 0 0 0 0 0 0 0 05028440888 0 // alu op 5
03 4124 0 0 0 0 0 0 0 0 11049000900 0 // load word
04 5012 0 0 0 0 0 0 0 0 11045800900 0 // load byte
05 635f 0 0 0 0 0 0 0 0 11056000800 0 // store word
06 7003 0 0 0 0 0 0 0 0 11042800800 0 // store byte
07 9840 0 0 0 0 0 0 0 0 00010020800 0 // jump base 2 offset 1
08 a408 0 0 0 0 0 0 0 0 00000011000 0 // jump base 1 offset 2
09 bd90 0 0 0 0 0 0 0 0 20026031980 0 // call
0a 0c60 0 0 0 0 0 0 0 0 00018000800 0 // system group
0b c535 1 c 3 1 1 5 6 0 3003110ab00 0 // debug over an alu op
0c 4124 1 1 0 2 2 4 f 0 00006208f80 0 // debug over a load
0d c270 0 0 0 0 0 0 0 1 0001c040888 0 // interrupt request raised
0e 0c60 0 0 0 0 0 0 0 0 00018208800 1 // takes the interrupt
0f 4124 0 0 0 0 0 0 0 0 11049000900 0 // back to sequential
10 9840 0 0 0 0 0 0 0 1 00010020800 0 // second request
11 0c60 1 0 0 0 0 0 0 0 00000000800 0 // debug, interrupt waits
12 c535 0 0 0 0 0 0 0 0 0100c648888 1 // taken after debug
13 7003 0 0 0 0 0 0 0 0 11042800800 0 // store byte, no ack
